// ==== rtl/bru_cfg.svh ====
`ifndef BRU_CFG_SVH
`define BRU_CFG_SVH

// Datapath and byte address widths
`define BRU_DW 32
`define BRU_AW 32

// log2 of instruction size in bytes
`define BRU_INSN_LEN 2

// Word-address PC
`define BRU_PC_W (`BRU_AW - `BRU_INSN_LEN)

// One-hot branch opcode bus
`define BRU_IOPW 8
`define BRU_BEQ 0
`define BRU_BNE 1
`define BRU_BGTU 2
`define BRU_BGT 3
`define BRU_BLEU 4
`define BRU_BLE 5
`define BRU_JMPREG 6
`define BRU_JMPREL 7

`endif

// ==== rtl/bru_pkg.sv ====
`default_nettype none

`include "bru_cfg.svh"

package bru_pkg;

   // Major opcodes of the branch group
   // Anything else decodes as a non-branch
   typedef enum logic [5:0] {
      BRU_MAJ_BEQ    = 6'h20,
      BRU_MAJ_BNE    = 6'h21,
      BRU_MAJ_BGTU   = 6'h22,
      BRU_MAJ_BGT    = 6'h23,
      BRU_MAJ_BLEU   = 6'h24,
      BRU_MAJ_BLE    = 6'h25,
      BRU_MAJ_JMPREG = 6'h26,
      BRU_MAJ_JMPREL = 6'h27
   } bru_major_e;

   // Conditional branch format
   typedef struct packed {
      logic signed [15:0] off;
      logic [4:0]         rs2;
      logic [4:0]         rs1;
      bru_major_e         major;
   } bru_bcc_fmt_t;

   // Jump format, 25-bit word offset
   typedef struct packed {
      logic signed [24:0] off;
      logic               lnk;
      bru_major_e         major;
   } bru_jmp_fmt_t;

   // Same 32-bit word, read through whichever view the major opcode picks
   typedef union packed {
      bru_bcc_fmt_t bcc;
      bru_jmp_fmt_t jmp;
   } bru_insn_u;

   // Decode stage register contents
   typedef struct packed {
      logic                   valid;
      logic [`BRU_IOPW-1:0]   opc_bus;
      logic [`BRU_PC_W-1:0]   pc;
      // Sign-extended bcc word offset
      logic [`BRU_DW-1:0]     imm;
      logic [`BRU_DW-1:0]     operand1;
      // JMPREL carries its byte offset here
      logic [`BRU_DW-1:0]     operand2;
      // Link request of a jump
      logic                   rf_we;
   } bru_dec_t;

   // Branch resolution
   typedef struct packed {
      logic                   b_taken;
      logic [`BRU_PC_W-1:0]   b_tgt;
      logic                   b_lnk;
      logic                   is_bcc;
      logic                   is_breg;
      logic                   is_brel;
   } bru_res_t;

endpackage

`default_nettype wire

// ==== rtl/bru_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bru_cfg.svh"

module bru_decode
   import bru_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  issue_valid,
   input  bru_insn_u             issue_insn,
   input  logic [`BRU_PC_W-1:0]  issue_pc,
   input  logic [`BRU_DW-1:0]    issue_operand1,
   input  logic [`BRU_DW-1:0]    issue_operand2,
   // Taken branch in execute
   input  logic                  flush,
   output bru_dec_t              dec
);

   logic [`BRU_IOPW-1:0]   opc_bus;
   logic                   is_bcc;
   logic                   is_jmp;
   logic [`BRU_DW-1:0]     bcc_imm;
   logic [`BRU_DW-1:0]     rel_off;
   logic [`BRU_DW-1:0]     imm;
   logic [`BRU_DW-1:0]     operand2;
   logic                   rf_we;
   bru_dec_t               dec_q;

   // Major opcode to one-hot bus
   // Major field sits at the same bits in both views
   always_comb begin
      opc_bus = '0;
      case (issue_insn.bcc.major)
         BRU_MAJ_BEQ: opc_bus[`BRU_BEQ] = 1'b1;
         BRU_MAJ_BNE: opc_bus[`BRU_BNE] = 1'b1;
         BRU_MAJ_BGTU: opc_bus[`BRU_BGTU] = 1'b1;
         BRU_MAJ_BGT: opc_bus[`BRU_BGT] = 1'b1;
         BRU_MAJ_BLEU: opc_bus[`BRU_BLEU] = 1'b1;
         BRU_MAJ_BLE: opc_bus[`BRU_BLE] = 1'b1;
         BRU_MAJ_JMPREG: opc_bus[`BRU_JMPREG] = 1'b1;
         BRU_MAJ_JMPREL: opc_bus[`BRU_JMPREL] = 1'b1;
         // Not a branch
         default: opc_bus = '0;
      endcase
   end

   // Instruction class
   assign is_bcc = opc_bus[`BRU_BEQ] |
                   opc_bus[`BRU_BNE] |
                   opc_bus[`BRU_BGTU] |
                   opc_bus[`BRU_BGT] |
                   opc_bus[`BRU_BLEU] |
                   opc_bus[`BRU_BLE];
   assign is_jmp = opc_bus[`BRU_JMPREG] | opc_bus[`BRU_JMPREL];

   // bcc view, 16-bit word offset
   assign bcc_imm = {{(`BRU_DW-16){issue_insn.bcc.off[15]}}, issue_insn.bcc.off};

   // jmp view, 25-bit word offset turned into a byte offset
   assign rel_off = {{(`BRU_DW-25-`BRU_INSN_LEN){issue_insn.jmp.off[24]}},
                     issue_insn.jmp.off,
                     {`BRU_INSN_LEN{1'b0}}};

   assign imm = is_bcc ? bcc_imm : '0;

   // JMPREL has no use for operand2, so it carries the offset
   assign operand2 = opc_bus[`BRU_JMPREL] ? rel_off : issue_operand2;

   // Link bit only means something for jumps
   assign rf_we = is_jmp & issue_insn.jmp.lnk;

   always_ff @(posedge clk) begin
      // Payload follows each issue
      if (issue_valid) begin
         dec_q.opc_bus <= opc_bus;
         dec_q.pc <= issue_pc;
         dec_q.imm <= imm;
         dec_q.operand1 <= issue_operand1;
         dec_q.operand2 <= operand2;
         dec_q.rf_we <= rf_we;
      end
      // Younger slot is dropped behind a taken branch
      if (reset) begin
         dec_q.valid <= 1'b0;
      end else begin
         dec_q.valid <= issue_valid & ~flush;
      end
   end

   assign dec = dec_q;

endmodule

`default_nettype wire

// ==== rtl/ex_bru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bru_cfg.svh"

module ex_bru
   import bru_pkg::*;
(
   input  logic                  ex_valid,
   input  logic [`BRU_IOPW-1:0]  ex_bru_opc_bus,
   input  logic [`BRU_PC_W-1:0]  ex_pc,
   input  logic [`BRU_DW-1:0]    ex_imm,
   input  logic [`BRU_DW-1:0]    ex_operand1,
   input  logic [`BRU_DW-1:0]    ex_operand2,
   input  logic                  ex_rf_we,
   // Subtractor result of operand2 minus operand1
   input  logic [`BRU_DW-1:0]    add_sum,
   input  logic                  add_carry,
   input  logic                  add_overflow,
   output bru_res_t              res
);

   logic                   cmp_eq;
   logic                   cmp_gt_s;
   logic                   cmp_gt_u;
   logic                   bcc_taken;
   logic                   is_bcc;
   logic                   is_breg;
   logic                   is_brel;
   logic [`BRU_PC_W-1:0]   bcc_tgt;
   logic [`BRU_PC_W-1:0]   rel_tgt;
   logic [`BRU_PC_W-1:0]   reg_tgt;

   // Flags
   // Zero difference means equal operands
   assign cmp_eq = (add_sum == '0);
   // Negative difference means operand1 is the larger
   assign cmp_gt_s = add_sum[`BRU_DW-1] ^ add_overflow;
   // Borrow out when operand1 is above operand2
   assign cmp_gt_u = ~add_carry;

   assign is_bcc = ex_bru_opc_bus[`BRU_BEQ] |
                   ex_bru_opc_bus[`BRU_BNE] |
                   ex_bru_opc_bus[`BRU_BGTU] |
                   ex_bru_opc_bus[`BRU_BGT] |
                   ex_bru_opc_bus[`BRU_BLEU] |
                   ex_bru_opc_bus[`BRU_BLE];
   assign is_breg = ex_bru_opc_bus[`BRU_JMPREG];
   assign is_brel = ex_bru_opc_bus[`BRU_JMPREL];

   // Condition per bcc
   assign bcc_taken = (ex_bru_opc_bus[`BRU_BEQ] & cmp_eq) |
                      (ex_bru_opc_bus[`BRU_BNE] & ~cmp_eq) |
                      (ex_bru_opc_bus[`BRU_BGTU] & cmp_gt_u) |
                      (ex_bru_opc_bus[`BRU_BGT] & cmp_gt_s) |
                      (ex_bru_opc_bus[`BRU_BLEU] & ~cmp_gt_u) |
                      (ex_bru_opc_bus[`BRU_BLE] & ~cmp_gt_s);

   // PC-relative target from the 16-bit word offset
   assign bcc_tgt = ex_pc + ex_imm[`BRU_PC_W-1:0];
   // PC-relative target from the byte offset in operand2
   assign rel_tgt = ex_pc + ex_operand2[`BRU_AW-1:`BRU_INSN_LEN];
   // Absolute target through operand1 with low bits ignored
   assign reg_tgt = ex_operand1[`BRU_AW-1:`BRU_INSN_LEN];

   always_comb begin
      res = '0;
      res.is_bcc = is_bcc;
      res.is_breg = is_breg;
      res.is_brel = is_brel;
      // Jumps are always taken
      res.b_taken = ex_valid & (bcc_taken | is_breg | is_brel);
      // Classes are one-hot so the OR acts as a mux
      res.b_tgt = ({`BRU_PC_W{is_bcc}} & bcc_tgt) |
                  ({`BRU_PC_W{is_brel}} & rel_tgt) |
                  ({`BRU_PC_W{is_breg}} & reg_tgt);
      res.b_lnk = (is_breg | is_brel) & ex_rf_we;
   end

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bru_cfg.svh"

module ex_stage
   import bru_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  bru_dec_t              dec,
   // To decode, kills the younger slot
   output logic                  flush,
   output logic                  resolved,
   output logic                  taken,
   output logic                  redirect_valid,
   output logic [`BRU_PC_W-1:0]  redirect_pc,
   output logic                  link_we,
   output logic [`BRU_DW-1:0]    link_data
);

   logic [`BRU_DW-1:0]     op1_n;
   logic [`BRU_DW-1:0]     add_sum;
   logic                   add_carry;
   logic                   add_overflow;
   bru_res_t               res;
   logic                   any_br;
   logic                   resolved_d;
   logic                   taken_d;
   logic                   link_we_d;
   logic [`BRU_PC_W-1:0]   link_pc;

   // Shared subtractor, operand2 + ~operand1 + 1
   assign op1_n = ~dec.operand1;
   assign {add_carry, add_sum} = {1'b0, dec.operand2} +
                                 {1'b0, op1_n} +
                                 {{`BRU_DW{1'b0}}, 1'b1};

   // Signed overflow
   // Operands differ in sign and result sign differs from minuend
   assign add_overflow = (dec.operand2[`BRU_DW-1] ^ dec.operand1[`BRU_DW-1]) &
                         (add_sum[`BRU_DW-1] ^ dec.operand2[`BRU_DW-1]);

   ex_bru i_ex_bru (
      .ex_valid       (dec.valid),
      .ex_bru_opc_bus (dec.opc_bus),
      .ex_pc          (dec.pc),
      .ex_imm         (dec.imm),
      .ex_operand1    (dec.operand1),
      .ex_operand2    (dec.operand2),
      .ex_rf_we       (dec.rf_we),
      .add_sum        (add_sum),
      .add_carry      (add_carry),
      .add_overflow   (add_overflow),
      .res            (res)
   );

   // Any branch class present
   assign any_br = res.is_bcc | res.is_breg | res.is_brel;

   // Only valid branches report
   assign resolved_d = dec.valid & any_br;
   assign taken_d = resolved_d & res.b_taken;
   assign link_we_d = resolved_d & res.b_lnk;

   // Fall-through is assumed, so taken means redirect
   assign flush = taken_d;

   // Return address, next word
   assign link_pc = dec.pc + 1'b1;

   // Control outputs
   always_ff @(posedge clk) begin
      if (reset) begin
         resolved <= 1'b0;
         taken <= 1'b0;
         redirect_valid <= 1'b0;
         link_we <= 1'b0;
      end else begin
         resolved <= resolved_d;
         taken <= taken_d;
         // Same as resolved and taken
         redirect_valid <= taken_d;
         link_we <= link_we_d;
      end
   end

   // Payload, held between branches
   always_ff @(posedge clk) begin
      if (resolved_d) begin
         redirect_pc <= res.b_tgt;
         // Word address back to bytes
         link_data <= {link_pc, {`BRU_INSN_LEN{1'b0}}};
      end
   end

endmodule

`default_nettype wire

// ==== rtl/bru_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bru_cfg.svh"

module bru_top
   import bru_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   // Issue strobe, no stall
   input  logic                  issue_valid,
   input  bru_insn_u             issue_insn,
   input  logic [`BRU_PC_W-1:0]  issue_pc,
   input  logic [`BRU_DW-1:0]    issue_operand1,
   input  logic [`BRU_DW-1:0]    issue_operand2,
   // Results, two cycles after issue
   output logic                  resolved,
   output logic                  taken,
   output logic                  redirect_valid,
   output logic [`BRU_PC_W-1:0]  redirect_pc,
   output logic                  link_we,
   output logic [`BRU_DW-1:0]    link_data
);

   bru_dec_t   dec;
   logic       flush;

   // Stage 1
   bru_decode i_bru_decode (
      .clk            (clk),
      .reset          (reset),
      .issue_valid    (issue_valid),
      .issue_insn     (issue_insn),
      .issue_pc       (issue_pc),
      .issue_operand1 (issue_operand1),
      .issue_operand2 (issue_operand2),
      .flush          (flush),
      .dec            (dec)
   );

   // Stage 2
   // Flush goes back to stage 1 in the same cycle
   ex_stage i_ex_stage (
      .clk            (clk),
      .reset          (reset),
      .dec            (dec),
      .flush          (flush),
      .resolved       (resolved),
      .taken          (taken),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .link_we        (link_we),
      .link_data      (link_data)
   );

endmodule

`default_nettype wire

// ==== verification/tb_bru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bru_cfg.svh"

module tb_bru
   import bru_pkg::*;
;

   localparam int NROWS = 26;
   localparam int PERIOD = 40;

   // Expected response of one issue slot
   typedef struct packed {
      logic                   resolved;
      logic                   taken;
      logic [`BRU_PC_W-1:0]   tgt;
      logic                   lnk;
      logic [`BRU_DW-1:0]     ldata;
   } exp_t;

   logic                   clk;
   logic                   reset;
   logic                   issue_valid;
   bru_insn_u              issue_insn;
   logic [`BRU_PC_W-1:0]   issue_pc;
   logic [`BRU_DW-1:0]     issue_operand1;
   logic [`BRU_DW-1:0]     issue_operand2;
   logic                   resolved;
   logic                   taken;
   logic                   redirect_valid;
   logic [`BRU_PC_W-1:0]   redirect_pc;
   logic                   link_we;
   logic [`BRU_DW-1:0]     link_data;

   // Stimulus table
   // Expected columns are unused on random rows
   logic [31:0]            t_insn [NROWS];
   logic [`BRU_PC_W-1:0]   t_pc [NROWS];
   logic [`BRU_DW-1:0]     t_op1 [NROWS];
   logic [`BRU_DW-1:0]     t_op2 [NROWS];
   logic                   t_rnd [NROWS];
   logic                   t_taken [NROWS];
   logic [`BRU_PC_W-1:0]   t_tgt [NROWS];
   logic                   t_lnk [NROWS];
   int                     nrow;

   exp_t                   exp_q [$];
   logic [31:0]            lcg_state;

   bru_top i_dut (
      .clk            (clk),
      .reset          (reset),
      .issue_valid    (issue_valid),
      .issue_insn     (issue_insn),
      .issue_pc       (issue_pc),
      .issue_operand1 (issue_operand1),
      .issue_operand2 (issue_operand2),
      .resolved       (resolved),
      .taken          (taken),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .link_we        (link_we),
      .link_data      (link_data)
   );

   always #(PERIOD/2) clk = ~clk;

   // Hang guard
   initial begin
      #((NROWS + 20) * PERIOD);
      $display("Timeout: simulation did not finish in time");
      $display("TEST FAIL");
      $fatal(1);
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [31:0] bcc_word(logic [5:0] major, logic [15:0] off);
      return {off, 5'd2, 5'd1, major};
   endfunction

   function automatic logic [31:0] jmp_word(logic [5:0] major, logic lnk, logic [24:0] off);
      return {off, lnk, major};
   endfunction

   task automatic add_row(logic [31:0] insn, logic [`BRU_PC_W-1:0] pc,
                          logic [31:0] op1, logic [31:0] op2, logic rnd,
                          logic tk, logic [`BRU_PC_W-1:0] tgt, logic lnk);
      t_insn[nrow] = insn;
      t_pc[nrow] = pc;
      t_op1[nrow] = op1;
      t_op2[nrow] = op2;
      t_rnd[nrow] = rnd;
      t_taken[nrow] = tk;
      t_tgt[nrow] = tgt;
      t_lnk[nrow] = lnk;
      nrow++;
   endtask

   // Branch rules straight from the ISA description
   function automatic exp_t model(logic [31:0] insn, logic [`BRU_PC_W-1:0] pc,
                                  logic [31:0] op1, logic [31:0] op2);
      exp_t e;
      logic [`BRU_PC_W-1:0] off16;
      logic [`BRU_PC_W-1:0] off25;
      e = '0;
      off16 = {{(`BRU_PC_W-16){insn[31]}}, insn[31:16]};
      off25 = {{(`BRU_PC_W-25){insn[31]}}, insn[31:7]};
      e.resolved = 1'b1;
      e.tgt = pc + off16;
      // Byte address of the next instruction
      e.ldata = ({{`BRU_INSN_LEN{1'b0}}, pc} + 32'd1) * 32'd4;
      case (insn[5:0])
         6'h20: e.taken = (op1 == op2);
         6'h21: e.taken = (op1 != op2);
         6'h22: e.taken = (op1 > op2);
         6'h23: e.taken = ($signed(op1) > $signed(op2));
         6'h24: e.taken = (op1 <= op2);
         6'h25: e.taken = ($signed(op1) <= $signed(op2));
         6'h26: begin
            e.taken = 1'b1;
            e.tgt = op1[31:2];
            e.lnk = insn[6];
         end
         6'h27: begin
            e.taken = 1'b1;
            e.tgt = pc + off25;
            e.lnk = insn[6];
         end
         default: e = '0;
      endcase
      return e;
   endfunction

   task automatic check(logic [31:0] act, logic [31:0] exp, string msg);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, msg, act, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_outputs(exp_t e, string tag);
      check(resolved, e.resolved, {tag, " resolved"});
      check(taken, e.taken, {tag, " taken"});
      check(redirect_valid, e.resolved & e.taken, {tag, " redirect_valid"});
      check(link_we, e.lnk, {tag, " link_we"});
      if (e.resolved) begin
         check(redirect_pc, e.tgt, {tag, " redirect_pc"});
      end
      if (e.lnk) begin
         check(link_data, e.ldata, {tag, " link_data"});
      end
   endtask

   initial begin
      exp_t e;
      logic prev_taken;
      string tag;
      clk = 1'b0;
      reset = 1'b1;
      issue_valid = 1'b0;
      issue_insn = '0;
      issue_pc = '0;
      issue_operand1 = '0;
      issue_operand2 = '0;
      lcg_state = 32'd68;
      nrow = 0;
      prev_taken = 1'b0;

      // Rows right after a taken branch get flushed
      // Their expected columns are only nominal
      add_row(bcc_word(BRU_MAJ_BEQ, 16'd8), 'h100, 5, 5, 0, 1, 'h108, 0);
      add_row(bcc_word(BRU_MAJ_BEQ, 16'd4), 'h104, 5, 5, 0, 1, 'h108, 0);
      add_row(bcc_word(BRU_MAJ_BNE, 16'hFFFC), 'h200, 7, 7, 0, 0, 'h1FC, 0);
      add_row(bcc_word(BRU_MAJ_BNE, 16'hFFF0), 'h204, 7, 9, 0, 1, 'h1F4, 0);
      add_row(32'h0000_0001, 'h208, 0, 0, 0, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BGT, 16'd3), 'h400, 1, 32'h8000_0000, 0, 1, 'h403, 0);
      add_row(bcc_word(BRU_MAJ_BGTU, 16'd3), 'h404, 1, 32'h8000_0000, 0, 0, 'h407, 0);
      add_row(bcc_word(BRU_MAJ_BGTU, 16'd5), 'h500, 32'h8000_0000, 1, 0, 1, 'h505, 0);
      add_row(32'h0000_0001, 'h504, 0, 0, 0, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BLE, 16'd6), 'h600, 32'h8000_0000, 1, 0, 1, 'h606, 0);
      add_row(jmp_word(BRU_MAJ_JMPREL, 1, 25'h10), 'h610, 0, 0, 0, 1, 'h620, 1);
      add_row(bcc_word(BRU_MAJ_BLEU, 16'd7), 'h700, 32'h8000_0000, 1, 0, 0, 'h707, 0);
      add_row(32'h1234_567F, 'h704, 3, 4, 0, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BGT, 16'd1), 'h800, 32'h8000_0000, 1, 0, 0, 'h801, 0);
      add_row(jmp_word(BRU_MAJ_JMPREL, 1, 25'h1FF_FFF8), 'h900, 0, 0, 0, 1, 'h8F8, 1);
      add_row(32'h0000_0002, 'h904, 0, 0, 0, 0, 0, 0);
      add_row(jmp_word(BRU_MAJ_JMPREL, 0, 25'h20), 'hA00, 0, 0, 0, 1, 'hA20, 0);
      add_row(bcc_word(BRU_MAJ_BEQ, 16'd1), 'hA04, 1, 1, 0, 1, 'hA05, 0);
      add_row(jmp_word(BRU_MAJ_JMPREG, 1, 25'h0), 'hB00, 32'h0000_4003, 0, 0, 1, 'h1000, 1);
      add_row(jmp_word(BRU_MAJ_JMPREG, 1, 25'h0), 'hB04, 32'h0000_8000, 0, 0, 1, 'h2000, 1);
      add_row(jmp_word(BRU_MAJ_JMPREG, 0, 25'h0), 'hC00, 32'hFFFF_FFF0, 0, 0, 1,
              'h3FFF_FFFC, 0);
      add_row(bcc_word(BRU_MAJ_BNE, 16'd2), 'hC04, 1, 2, 0, 1, 'hC06, 0);
      add_row(bcc_word(BRU_MAJ_BGTU, 16'd9), 'hD00, lcg_next(), lcg_next(), 1, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BLEU, 16'd9), 'hD04, lcg_next(), lcg_next(), 1, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BLE, 16'd9), 'hD08, lcg_next(), lcg_next(), 1, 0, 0, 0);
      add_row(bcc_word(BRU_MAJ_BGT, 16'd9), 'hD0C, lcg_next(), lcg_next(), 1, 0, 0, 0);

      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      // Quiet outputs right after reset and at the first edge before any issue
      exp_q.push_back('0);
      exp_q.push_back('0);

      for (int i = 0; i < NROWS + 2; i++) begin
         if (i > 0) begin
            @(posedge clk);
            #2;
         end
         // Row issued two cycles ago is now at the outputs
         if (exp_q.size() == 2) begin
            if (i < 2) begin
               tag = "after reset";
            end else begin
               tag = $sformatf("slot %0d", i - 2);
            end
            check_outputs(exp_q.pop_front(), tag);
         end
         if (i < NROWS) begin
            e = model(t_insn[i], t_pc[i], t_op1[i], t_op2[i]);
            if (!t_rnd[i] && e.resolved) begin
               check(e.taken, t_taken[i], $sformatf("table row %0d taken", i));
               check(e.tgt, t_tgt[i], $sformatf("table row %0d target", i));
               check(e.lnk, t_lnk[i], $sformatf("table row %0d link", i));
            end
            if (prev_taken) begin
               e = '0;
            end
            issue_valid = 1'b1;
            issue_insn = t_insn[i];
            issue_pc = t_pc[i];
            issue_operand1 = t_op1[i];
            issue_operand2 = t_op2[i];
         end else begin
            e = '0;
            issue_valid = 1'b0;
            issue_insn = '0;
         end
         prev_taken = e.resolved & e.taken;
         exp_q.push_back(e);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/bru_pkg.sv
rtl/bru_decode.sv
rtl/ex_bru.sv
rtl/ex_stage.sv
rtl/bru_top.sv
verification/tb_bru.sv

// ==== Bender.yml ====
package:
  name: bru

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bru_pkg.sv
      - rtl/bru_decode.sv
      - rtl/ex_bru.sv
      - rtl/ex_stage.sv
      - rtl/bru_top.sv
      - target: test
        files:
          - verification/tb_bru.sv
